// File: design/aluExecute.sv
/* condition check, ALU and branch target, one registered cycle
   flags are read here as they stand before this instruction commits */
`timescale 1ns/1ps
`include "core_cfg.svh"

module aluExecute (
	input  logic clk,
	input  logic arstN,
	input  logic decValid,
	input  corePkg::instrKindT decKind,
	input  corePkg::aluOpT decOp,
	input  corePkg::condT decCond,
	input  logic decSetFlags,
	input  logic [`CORE_REG_ADDR_W-1:0] decRd,
	input  logic [`CORE_DATA_W-1:0] decRnData,
	input  logic [`CORE_DATA_W-1:0] decOperand2,
	input  logic decShiftCarry,
	input  logic [23:0] decOffset,
	input  logic [`CORE_DATA_W-1:0] decPc,
	input  corePkg::flagsT flags,
	output logic exeValid,
	output logic exeWrEn,
	output logic [`CORE_REG_ADDR_W-1:0] exeRd,
	output logic [`CORE_DATA_W-1:0] exeResult,
	output logic exeFlagsEn,
	output corePkg::flagsT exeFlags,
	output logic exeBranch,
	output logic [`CORE_DATA_W-1:0] exeTarget
);
	logic condPass;
	logic isDp;
	logic isBranch;
	logic isCompare;
	logic isArith;
	logic [`CORE_DATA_W-1:0] addA;
	logic [`CORE_DATA_W-1:0] addB;
	logic addCin;
	logic [`CORE_DATA_W:0] sum;
	logic [`CORE_DATA_W-1:0] logicRes;
	logic [`CORE_DATA_W-1:0] result;
	corePkg::flagsT dpFlags;
	logic [`CORE_DATA_W-1:0] target;

	always_comb begin
		unique case (decCond)
			corePkg::condEq: condPass = flags.z;
			corePkg::condNe: condPass = !flags.z;
			corePkg::condCs: condPass = flags.c;
			corePkg::condCc: condPass = !flags.c;
			corePkg::condMi: condPass = flags.n;
			corePkg::condPl: condPass = !flags.n;
			corePkg::condVs: condPass = flags.v;
			corePkg::condVc: condPass = !flags.v;
			corePkg::condHi: condPass = flags.c && !flags.z;
			corePkg::condLs: condPass = !flags.c || flags.z;
			corePkg::condGe: condPass = flags.n == flags.v;
			corePkg::condLt: condPass = flags.n != flags.v;
			corePkg::condGt: condPass = !flags.z && (flags.n == flags.v);
			corePkg::condLe: condPass = flags.z || (flags.n != flags.v);
			default: condPass = 1'b1; // AL and code 15
		endcase
	end

	assign isDp = decKind == corePkg::kindDataProc;
	assign isBranch = decKind == corePkg::kindBranch;
	assign isCompare = decOp inside {corePkg::opTst, corePkg::opTeq,
		corePkg::opCmp, corePkg::opCmn};

	// subtracts run as a + ~b + carry, so carry out is "no borrow"
	always_comb begin
		addA = decRnData;
		addB = decOperand2;
		addCin = 1'b0;
		isArith = 1'b1;
		logicRes = decOperand2;
		unique case (decOp)
			corePkg::opAnd, corePkg::opTst: begin
				isArith = 1'b0;
				logicRes = decRnData & decOperand2;
			end
			corePkg::opEor, corePkg::opTeq: begin
				isArith = 1'b0;
				logicRes = decRnData ^ decOperand2;
			end
			corePkg::opSub, corePkg::opCmp: begin
				addB = ~decOperand2;
				addCin = 1'b1;
			end
			corePkg::opRsb, corePkg::opRsc: begin
				addA = decOperand2;
				addB = ~decRnData;
				addCin = (decOp == corePkg::opRsb) ? 1'b1 : flags.c;
			end
			corePkg::opAdd, corePkg::opCmn: addCin = 1'b0;
			corePkg::opAdc: addCin = flags.c;
			corePkg::opSbc: begin
				addB = ~decOperand2;
				addCin = flags.c;
			end
			corePkg::opOrr: begin
				isArith = 1'b0;
				logicRes = decRnData | decOperand2;
			end
			corePkg::opMov: isArith = 1'b0;
			corePkg::opBic: begin
				isArith = 1'b0;
				logicRes = decRnData & ~decOperand2;
			end
			corePkg::opMvn: begin
				isArith = 1'b0;
				logicRes = ~decOperand2;
			end
		endcase
	end

	assign sum = {1'b0, addA} + {1'b0, addB} + {{`CORE_DATA_W{1'b0}}, addCin};
	assign result = isArith ? sum[`CORE_DATA_W-1:0] : logicRes;
	assign dpFlags.n = result[`CORE_DATA_W-1];
	assign dpFlags.z = result == '0;
	assign dpFlags.c = isArith ? sum[`CORE_DATA_W] : decShiftCarry; // shifter carry for logic ops
	assign dpFlags.v = isArith ? (addA[`CORE_DATA_W-1] == addB[`CORE_DATA_W-1]) &&
		(sum[`CORE_DATA_W-1] != addA[`CORE_DATA_W-1]) : flags.v;

	assign target = decPc + `CORE_PC_AHEAD +
		{{(`CORE_DATA_W-26){decOffset[23]}}, decOffset, 2'b00};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exeValid <= 1'b0;
			exeWrEn <= 1'b0;
			exeFlagsEn <= 1'b0;
			exeBranch <= 1'b0;
		end else begin
			exeValid <= decValid; // also for failed conditions, with all enables low
			exeWrEn <= decValid && condPass &&
				((isDp && !isCompare) || (isBranch && decOp[3]));
			exeFlagsEn <= decValid && condPass && isDp && decSetFlags;
			exeBranch <= decValid && condPass && isBranch;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			exeRd <= isBranch ? `CORE_LINK_REG : decRd;
			exeResult <= isBranch ? decPc + `CORE_PC_STEP : result; // BL return address
			exeFlags <= dpFlags;
			exeTarget <= target;
		end
	end

	// one instruction in flight, so decode never hands over on two edges in a row
	assert property (@(posedge clk) disable iff (!arstN)
		decValid |=> !decValid);
endmodule

// File: design/armCore.sv
/* multicycle ARM-style execution core: decode, execute, commit
   one instruction in flight; loads, stores and register-specified shifts are not supported */
`timescale 1ns/1ps
`include "core_cfg.svh"

module armCore (
	input  logic clk,
	input  logic arstN,
	input  logic [`CORE_DATA_W-1:0] instr,
	input  logic instrValid,
	output logic instrReady,
	output logic [`CORE_DATA_W-1:0] pc,
	output logic regWrValid,
	output logic [`CORE_REG_ADDR_W-1:0] regWrAddr,
	output logic [`CORE_DATA_W-1:0] regWrData,
	output logic branchTaken,
	output corePkg::flagsT flags
);
	// register file reads
	logic [`CORE_REG_ADDR_W-1:0] rnAddr;
	logic [`CORE_REG_ADDR_W-1:0] rmAddr;
	logic [`CORE_DATA_W-1:0] rnData;
	logic [`CORE_DATA_W-1:0] rmData;

	// commit feedback to decode
	logic commitDone;
	logic branchNow;
	logic [`CORE_DATA_W-1:0] branchTarget;

	// decode to execute
	logic decValid;
	corePkg::instrKindT decKind;
	corePkg::aluOpT decOp;
	corePkg::condT decCond;
	logic decSetFlags;
	logic [`CORE_REG_ADDR_W-1:0] decRd;
	logic [`CORE_DATA_W-1:0] decRnData;
	logic [`CORE_DATA_W-1:0] decOperand2;
	logic decShiftCarry;
	logic [23:0] decOffset;
	logic [`CORE_DATA_W-1:0] decPc;

	// execute to commit
	logic exeValid;
	logic exeWrEn;
	logic [`CORE_REG_ADDR_W-1:0] exeRd;
	logic [`CORE_DATA_W-1:0] exeResult;
	logic exeFlagsEn;
	corePkg::flagsT exeFlags;
	logic exeBranch;
	logic [`CORE_DATA_W-1:0] exeTarget;

	instrDecode decode (
		.clk(clk), .arstN(arstN),
		.instr(instr), .instrValid(instrValid), .instrReady(instrReady), .pc(pc),
		.rnData(rnData), .rmData(rmData), .rnAddr(rnAddr), .rmAddr(rmAddr),
		.carryIn(flags.c), // shifter carry for zero shifts
		.commitDone(commitDone), .branchTaken(branchNow), .branchTarget(branchTarget),
		.decValid(decValid), .decKind(decKind), .decOp(decOp), .decCond(decCond),
		.decSetFlags(decSetFlags), .decRd(decRd), .decRnData(decRnData),
		.decOperand2(decOperand2), .decShiftCarry(decShiftCarry),
		.decOffset(decOffset), .decPc(decPc)
	);

	aluExecute execute (
		.clk(clk), .arstN(arstN),
		.decValid(decValid), .decKind(decKind), .decOp(decOp), .decCond(decCond),
		.decSetFlags(decSetFlags), .decRd(decRd), .decRnData(decRnData),
		.decOperand2(decOperand2), .decShiftCarry(decShiftCarry),
		.decOffset(decOffset), .decPc(decPc), .flags(flags),
		.exeValid(exeValid), .exeWrEn(exeWrEn), .exeRd(exeRd), .exeResult(exeResult),
		.exeFlagsEn(exeFlagsEn), .exeFlags(exeFlags),
		.exeBranch(exeBranch), .exeTarget(exeTarget)
	);

	resultWriteback writeback (
		.clk(clk), .arstN(arstN),
		.exeValid(exeValid), .exeWrEn(exeWrEn), .exeRd(exeRd), .exeResult(exeResult),
		.exeFlagsEn(exeFlagsEn), .exeFlags(exeFlags),
		.exeBranch(exeBranch), .exeTarget(exeTarget),
		.rnAddr(rnAddr), .rmAddr(rmAddr), .rnData(rnData), .rmData(rmData),
		.flags(flags), .commitDone(commitDone), .branchNow(branchNow),
		.regWrValid(regWrValid), .regWrAddr(regWrAddr), .regWrData(regWrData),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);
endmodule

// File: design/corePkg.sv
/* shared types of the execution core
   encodings follow the ARM data-processing and condition fields */
package corePkg;

	// opcode field, bits 24:21 of a data-processing word
	typedef enum logic [3:0] {
		opAnd = 4'b0000,
		opEor = 4'b0001,
		opSub = 4'b0010,
		opRsb = 4'b0011,
		opAdd = 4'b0100,
		opAdc = 4'b0101,
		opSbc = 4'b0110,
		opRsc = 4'b0111,
		opTst = 4'b1000,
		opTeq = 4'b1001,
		opCmp = 4'b1010,
		opCmn = 4'b1011,
		opOrr = 4'b1100,
		opMov = 4'b1101,
		opBic = 4'b1110,
		opMvn = 4'b1111
	} aluOpT;

	// condition field, bits 31:28; code 15 is run as always
	typedef enum logic [3:0] {
		condEq = 4'b0000,
		condNe = 4'b0001,
		condCs = 4'b0010,
		condCc = 4'b0011,
		condMi = 4'b0100,
		condPl = 4'b0101,
		condVs = 4'b0110,
		condVc = 4'b0111,
		condHi = 4'b1000,
		condLs = 4'b1001,
		condGe = 4'b1010,
		condLt = 4'b1011,
		condGt = 4'b1100,
		condLe = 4'b1101,
		condAl = 4'b1110
	} condT;

	typedef enum logic [1:0] {
		shLsl = 2'b00,
		shLsr = 2'b01,
		shAsr = 2'b10,
		shRor = 2'b11
	} shiftKindT;

	// same bit order as CPSR[31:28]
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

	typedef enum logic [1:0] {
		kindDataProc = 2'b00,
		kindBranch = 2'b01,
		kindUnsupported = 2'b10
	} instrKindT;

endpackage

// File: design/core_cfg.svh
/* widths and constants of the execution core
   the datapath is fixed at 32 bits because the branch offset and shifter assume it */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and register file
`define CORE_DATA_W 32
`define CORE_REG_ADDR_W 4
`define CORE_REG_CNT 16

// BL return address goes here
`define CORE_LINK_REG 4'd14

// pc arithmetic
`define CORE_PC_STEP 32'd4
`define CORE_PC_AHEAD 32'd8 // read-ahead of the classic three-stage pipe

`endif

// File: design/instrDecode.sv
/* accepts one instruction at a time and keeps the pc
   register sources are read the same edge the word is accepted; bit 4 is ignored */
`timescale 1ns/1ps
`include "core_cfg.svh"

module instrDecode (
	input  logic clk,
	input  logic arstN,
	input  logic [`CORE_DATA_W-1:0] instr,
	input  logic instrValid,
	input  logic [`CORE_DATA_W-1:0] rnData,
	input  logic [`CORE_DATA_W-1:0] rmData,
	input  logic carryIn,
	input  logic commitDone,
	input  logic branchTaken,
	input  logic [`CORE_DATA_W-1:0] branchTarget,
	output logic instrReady,
	output logic [`CORE_DATA_W-1:0] pc,
	output logic [`CORE_REG_ADDR_W-1:0] rnAddr,
	output logic [`CORE_REG_ADDR_W-1:0] rmAddr,
	output logic decValid,
	output corePkg::instrKindT decKind,
	output corePkg::aluOpT decOp,
	output corePkg::condT decCond,
	output logic decSetFlags,
	output logic [`CORE_REG_ADDR_W-1:0] decRd,
	output logic [`CORE_DATA_W-1:0] decRnData,
	output logic [`CORE_DATA_W-1:0] decOperand2,
	output logic decShiftCarry,
	output logic [23:0] decOffset,
	output logic [`CORE_DATA_W-1:0] decPc
);
	logic busy;
	logic accept;
	corePkg::instrKindT kind;
	logic [`CORE_DATA_W-1:0] operand2;
	logic shiftCarry;

	assign instrReady = ~busy;
	assign accept = instrValid & instrReady;
	assign rnAddr = instr[19:16];
	assign rmAddr = instr[3:0];

	always_comb begin
		if (instr[27:26] == 2'b00)
			kind = corePkg::kindDataProc;
		else if (instr[27:25] == 3'b101)
			kind = corePkg::kindBranch;
		else
			kind = corePkg::kindUnsupported; // flows through, commits nothing
	end

	operandShifter shifter (
		.immediate(instr[25]),
		.operandField(instr[11:0]),
		.rmData(rmData),
		.carryIn(carryIn),
		.operand2(operand2),
		.shiftCarry(shiftCarry)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			decValid <= 1'b0;
			pc <= '0;
		end else begin
			decValid <= accept;
			if (accept)
				busy <= 1'b1;
			else if (commitDone)
				busy <= 1'b0;
			if (accept)
				pc <= pc + `CORE_PC_STEP;
			else if (branchTaken)
				pc <= branchTarget; // commit edge of a taken branch
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			decKind <= kind;
			decOp <= corePkg::aluOpT'(instr[24:21]); // bit 24 is also the link bit of B/BL
			decCond <= corePkg::condT'(instr[31:28]);
			decSetFlags <= instr[20];
			decRd <= instr[15:12];
			decRnData <= rnData;
			decOperand2 <= operand2;
			decShiftCarry <= shiftCarry;
			decOffset <= instr[23:0];
			decPc <= pc;
		end
	end

	// ready stays low through execute and commit, back one cycle later
	assert property (@(posedge clk) disable iff (!arstN)
		(instrValid && instrReady) |=> !instrReady ##1 !instrReady ##1 instrReady);
endmodule

// File: design/operandShifter.sv
/* combinational second-operand former
   register-specified shift amounts are not handled; ROR by zero is a plain pass (no RRX) */
`timescale 1ns/1ps
`include "core_cfg.svh"

module operandShifter (
	input  logic immediate,
	input  logic [11:0] operandField,
	input  logic [`CORE_DATA_W-1:0] rmData,
	input  logic carryIn,
	output logic [`CORE_DATA_W-1:0] operand2,
	output logic shiftCarry
);
	logic [4:0] rotAmt;
	logic [4:0] shAmt;
	corePkg::shiftKindT kind;
	logic [`CORE_DATA_W-1:0] imm32;
	logic [2*`CORE_DATA_W-1:0] rotImm;
	logic [2*`CORE_DATA_W-1:0] rorReg;
	logic [`CORE_DATA_W:0] lslWide;
	logic [`CORE_DATA_W:0] lsrWide;
	logic signed [`CORE_DATA_W:0] asrWide;

	assign rotAmt = {operandField[11:8], 1'b0}; // twice the rotate field
	assign shAmt = operandField[11:7];
	assign kind = corePkg::shiftKindT'(operandField[6:5]);
	assign imm32 = {{(`CORE_DATA_W-8){1'b0}}, operandField[7:0]};

	// doubled words make rotates a plain right shift
	assign rotImm = {imm32, imm32} >> rotAmt;
	assign rorReg = {rmData, rmData} >> shAmt;
	assign lslWide = {1'b0, rmData} << shAmt; // top bit is the last one out
	assign lsrWide = {rmData, 1'b0} >> shAmt; // bit 0 is the last one out
	assign asrWide = $signed({rmData, 1'b0}) >>> shAmt;

	always_comb begin
		operand2 = rmData;
		shiftCarry = carryIn;
		if (immediate) begin
			operand2 = rotImm[`CORE_DATA_W-1:0];
			if (rotAmt != 5'd0)
				shiftCarry = rotImm[`CORE_DATA_W-1];
		end else begin
			unique case (kind)
				corePkg::shLsl: begin
					if (shAmt != 5'd0) begin
						operand2 = lslWide[`CORE_DATA_W-1:0];
						shiftCarry = lslWide[`CORE_DATA_W];
					end
				end
				corePkg::shLsr: begin
					operand2 = (shAmt == 5'd0) ? '0 : lsrWide[`CORE_DATA_W:1]; // zero means 32
					shiftCarry = (shAmt == 5'd0) ? rmData[`CORE_DATA_W-1] : lsrWide[0];
				end
				corePkg::shAsr: begin
					operand2 = (shAmt == 5'd0) ? {`CORE_DATA_W{rmData[`CORE_DATA_W-1]}}
						: asrWide[`CORE_DATA_W:1];
					shiftCarry = (shAmt == 5'd0) ? rmData[`CORE_DATA_W-1] : asrWide[0];
				end
				corePkg::shRor: begin
					if (shAmt != 5'd0) begin
						operand2 = rorReg[`CORE_DATA_W-1:0];
						shiftCarry = rorReg[`CORE_DATA_W-1];
					end
				end
			endcase
		end
	end
endmodule

// File: design/resultWriteback.sv
/* register file, CPSR flags and commit of results
   reads are combinational; a write is visible the cycle after its commit edge */
`timescale 1ns/1ps
`include "core_cfg.svh"

module resultWriteback (
	input  logic clk,
	input  logic arstN,
	input  logic exeValid,
	input  logic exeWrEn,
	input  logic [`CORE_REG_ADDR_W-1:0] exeRd,
	input  logic [`CORE_DATA_W-1:0] exeResult,
	input  logic exeFlagsEn,
	input  corePkg::flagsT exeFlags,
	input  logic exeBranch,
	input  logic [`CORE_DATA_W-1:0] exeTarget,
	input  logic [`CORE_REG_ADDR_W-1:0] rnAddr,
	input  logic [`CORE_REG_ADDR_W-1:0] rmAddr,
	output logic [`CORE_DATA_W-1:0] rnData,
	output logic [`CORE_DATA_W-1:0] rmData,
	output corePkg::flagsT flags,
	output logic commitDone,
	output logic branchNow,
	output logic regWrValid,
	output logic [`CORE_REG_ADDR_W-1:0] regWrAddr,
	output logic [`CORE_DATA_W-1:0] regWrData,
	output logic branchTaken,
	output logic [`CORE_DATA_W-1:0] branchTarget
);
	logic [`CORE_DATA_W-1:0] regFile [`CORE_REG_CNT];

	assign rnData = regFile[rnAddr];
	assign rmData = regFile[rmAddr];

	// the pc loads on the same edge the branch commits
	assign commitDone = exeValid;
	assign branchNow = exeValid && exeBranch;
	assign branchTarget = exeTarget;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `CORE_REG_CNT; i++)
				regFile[i] <= '0;
			flags <= '0;
			regWrValid <= 1'b0;
			branchTaken <= 1'b0;
		end else begin
			if (exeValid && exeWrEn)
				regFile[exeRd] <= exeResult;
			if (exeValid && exeFlagsEn)
				flags <= exeFlags;
			regWrValid <= exeValid && exeWrEn; // one-cycle commit pulses
			branchTaken <= branchNow;
		end
	end

	always_ff @(posedge clk) begin
		if (exeValid && exeWrEn) begin
			regWrAddr <= exeRd;
			regWrData <= exeResult;
		end
	end

	// one instruction in flight, so commits never come back to back
	assert property (@(posedge clk) disable iff (!arstN)
		regWrValid |=> !regWrValid);
	assert property (@(posedge clk) disable iff (!arstN)
		branchTaken |=> !branchTaken);
endmodule

// File: run.sh
#!/bin/bash
# build the core testbench with Verilator, run it, and fail on the fail message in the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sim.f --top-module armCoreTb -o armCoreSim

./obj_dir/armCoreSim 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi

// File: sim.f
+incdir+design
+incdir+tests
design/corePkg.sv
design/operandShifter.sv
design/instrDecode.sv
design/aluExecute.sv
design/resultWriteback.sv
design/armCore.sv
tests/armCoreTb.sv

// File: tests/refModel.svh
/* expected results of the core, worked out from the ARM data-processing and branch rules
   flags are kept in CPSR order n z c v and condition 15 counts as always */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

function automatic logic condHolds(input logic [3:0] cond, input corePkg::flagsT f);
	case (cond)
		4'h0: return f.z;
		4'h1: return !f.z;
		4'h2: return f.c;
		4'h3: return !f.c;
		4'h4: return f.n;
		4'h5: return !f.n;
		4'h6: return f.v;
		4'h7: return !f.v;
		4'h8: return f.c && !f.z; // HI
		4'h9: return !f.c || f.z; // LS
		4'ha: return f.n == f.v;
		4'hb: return f.n != f.v;
		4'hc: return !f.z && (f.n == f.v);
		4'hd: return f.z || (f.n != f.v);
		default: return 1'b1;
	endcase
endfunction

// second operand and the carry out of the shifter
function automatic logic [31:0] secondOperand(input logic immForm, input logic [11:0] field,
		input logic [31:0] rm, input logic cin, output logic cout);
	int amt;
	logic [31:0] val;
	cout = cin;
	if (immForm) begin
		amt = 2 * int'(field[11:8]);
		val = {24'h0, field[7:0]};
		if (amt != 0) begin
			val = (val >> amt) | (val << (32 - amt));
			cout = val[31];
		end
		return val;
	end
	amt = int'(field[11:7]);
	if (field[6:5] == 2'd0) begin
		if (amt == 0)
			return rm;
		cout = rm[32 - amt];
		return rm << amt;
	end
	if (field[6:5] == 2'd3) begin
		if (amt == 0)
			return rm; // no RRX here
		cout = rm[amt - 1];
		return (rm >> amt) | (rm << (32 - amt));
	end
	if (amt == 0)
		amt = 32; // LSR and ASR by zero mean 32
	cout = rm[amt - 1];
	if (field[6:5] == 2'd1)
		return rm >> amt;
	val = $signed(rm) >>> amt; // sign fills from the left
	return val;
endfunction

function automatic logic [31:0] dataProc(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic shCarry, input corePkg::flagsT fin,
		output corePkg::flagsT fout);
	logic [32:0] wide;
	logic [31:0] res;
	logic [31:0] x;
	logic [31:0] y;
	logic cin;
	logic subtract;
	x = (op == 4'h3 || op == 4'h7) ? b : a; // reverse forms swap operands
	y = (op == 4'h3 || op == 4'h7) ? a : b;
	subtract = op inside {4'h2, 4'h3, 4'h6, 4'h7, 4'ha};
	cin = (op == 4'h5) ? fin.c : ((op == 4'h6 || op == 4'h7) ? !fin.c : 1'b0);
	fout = fin;
	if (op inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'ha, 4'hb}) begin
		if (subtract) begin
			res = x - y - 32'(cin); // cin is a borrow here
			fout.c = {1'b0, x} >= ({1'b0, y} + 33'(cin));
			fout.v = (x[31] != y[31]) && (res[31] != x[31]);
		end else begin
			wide = {1'b0, x} + {1'b0, y} + 33'(cin);
			res = wide[31:0];
			fout.c = wide[32];
			fout.v = (x[31] == y[31]) && (res[31] != x[31]);
		end
	end else begin
		case (op)
			4'h0, 4'h8: res = a & b;
			4'h1, 4'h9: res = a ^ b;
			4'hc: res = a | b;
			4'hd: res = b;
			4'he: res = a & ~b;
			default: res = ~b;
		endcase
		fout.c = shCarry; // v stays as it was
	end
	fout.n = res[31];
	fout.z = res == 32'h0;
	return res;
endfunction

// TST TEQ CMP CMN are 10xx and never write
function automatic logic writesRd(input logic [3:0] op);
	return op[3:2] != 2'b10;
endfunction

function automatic logic [31:0] branchTarget(input logic [31:0] at, input logic [23:0] offset);
	logic [31:0] words;
	words = {{8{offset[23]}}, offset};
	return at + `CORE_PC_AHEAD + (words << 2);
endfunction

`endif

// File: tests/armCoreTb.sv
/* testbench of the execution core with random instructions checked against a reference model
   one instruction in flight and the next one is sent a cycle after each commit */
`timescale 1ns/1ps
`include "core_cfg.svh"

module armCoreTb;
	localparam int resetCycles = 5;
	localparam int loadCount = 8;
	localparam int instrCount = 3 * loadCount + 32 + 30 + 22; // loads, then the three tests

	logic clk = 1'b0;
	logic arstN;
	logic [31:0] instr;
	logic instrValid;
	logic instrReady;
	logic [31:0] pc;
	logic regWrValid;
	logic [3:0] regWrAddr;
	logic [31:0] regWrData;
	logic branchTaken;
	corePkg::flagsT flags;
	logic accepted;

	int seed = 5;
	int valueErrors = 0;
	int protocolErrors = 0;

	// model state, and what the next commit has to show
	logic [31:0] modelRegs [16];
	corePkg::flagsT modelFlags;
	logic [31:0] modelPc;
	logic [31:0] expPcStep;
	logic [31:0] expPc;
	logic expWrValid;
	logic [3:0] expWrAddr;
	logic [31:0] expWrData;
	logic expBranch;
	corePkg::flagsT expFlags;

	`include "refModel.svh"

	armCore dut (
		.clk(clk), .arstN(arstN), .instr(instr), .instrValid(instrValid),
		.instrReady(instrReady), .pc(pc), .regWrValid(regWrValid), .regWrAddr(regWrAddr),
		.regWrData(regWrData), .branchTaken(branchTaken), .flags(flags)
	);

	always #10 clk = ~clk;
	assign accepted = instrValid && instrReady;

	// first edge after reset release
	assert property (@(posedge clk) $rose(arstN) |-> instrReady && !regWrValid && !branchTaken)
		else begin
			protocolErrors++;
			$display("instrReady low or a commit pulse high right after reset");
		end
	assert property (@(posedge clk) $rose(arstN) |-> pc == 32'h0 && flags == 4'h0)
		else begin
			valueErrors++;
			$display("error: pc/flags expected 00000000/0 got %h/%h", $sampled(pc),
				$sampled(flags));
		end

	// handshake
	assert property (@(posedge clk) disable iff (!arstN)
		($past(accepted) || $past(accepted, 2)) |-> !instrReady)
		else begin
			protocolErrors++;
			$display("instrReady high while an instruction is still in flight");
		end
	assert property (@(posedge clk) disable iff (!arstN) $past(accepted, 3) |-> instrReady)
		else begin
			protocolErrors++;
			$display("instrReady did not return three edges after acceptance");
		end
	assert property (@(posedge clk) disable iff (!arstN) $past(accepted) |-> pc == expPcStep)
		else begin
			valueErrors++;
			$display("error: pc expected %h got %h", expPcStep, $sampled(pc));
		end

	// commit results, seen in the cycle where instrReady comes back
	assert property (@(posedge clk) disable iff (!arstN)
		$rose(instrReady) |-> regWrValid == expWrValid)
		else begin
			valueErrors++;
			$display("error: regWrValid expected %h got %h", expWrValid, $sampled(regWrValid));
		end
	assert property (@(posedge clk) disable iff (!arstN)
		$rose(instrReady) && expWrValid |-> regWrAddr == expWrAddr)
		else begin
			valueErrors++;
			$display("error: regWrAddr expected %h got %h", expWrAddr, $sampled(regWrAddr));
		end
	assert property (@(posedge clk) disable iff (!arstN)
		$rose(instrReady) && expWrValid |-> regWrData == expWrData)
		else begin
			valueErrors++;
			$display("error: regWrData expected %h got %h", expWrData, $sampled(regWrData));
		end
	assert property (@(posedge clk) disable iff (!arstN)
		$rose(instrReady) |-> branchTaken == expBranch)
		else begin
			valueErrors++;
			$display("error: branchTaken expected %h got %h", expBranch, $sampled(branchTaken));
		end
	assert property (@(posedge clk) disable iff (!arstN) $rose(instrReady) |-> flags == expFlags)
		else begin
			valueErrors++;
			$display("error: flags expected %h got %h", expFlags, $sampled(flags));
		end
	assert property (@(posedge clk) disable iff (!arstN) $rose(instrReady) |-> pc == expPc)
		else begin
			valueErrors++;
			$display("error: pc expected %h got %h", expPc, $sampled(pc));
		end
	assert property (@(posedge clk) disable iff (!arstN)
		!$rose(instrReady) |-> !regWrValid && !branchTaken)
		else begin
			protocolErrors++;
			$display("register write or branch pulse outside the commit cycle");
		end

	function automatic logic [31:0] dpWord(input logic [3:0] cond, input logic [3:0] op,
			input logic immForm, input logic setFlags, input logic [3:0] rn,
			input logic [3:0] rd, input logic [11:0] field);
		return {cond, 2'b00, immForm, op, setFlags, rn, rd, field};
	endfunction

	// shift by immediate, bit 4 clear, rm in r0..r7
	function automatic logic [11:0] regField(input logic [31:0] rnd);
		return {rnd[11:5], 2'b00, rnd[2:0]};
	endfunction

	function automatic logic [31:0] branchWord(input logic [3:0] cond, input logic link,
			input logic [4:0] hop);
		return {cond, 3'b101, link, {19{hop[4]}}, hop};
	endfunction

	// sets the expectations for one instruction and steps the model
	task automatic predictCommit(input logic [31:0] word);
		logic shCarry;
		logic [31:0] op2;
		logic [31:0] res;
		corePkg::flagsT newFlags;
		expPcStep = modelPc + `CORE_PC_STEP;
		expPc = modelPc + `CORE_PC_STEP;
		expWrValid = 1'b0;
		expBranch = 1'b0;
		expFlags = modelFlags;
		if (condHolds(word[31:28], modelFlags) && word[27:26] == 2'b00) begin
			op2 = secondOperand(word[25], word[11:0], modelRegs[word[3:0]], modelFlags.c,
				shCarry);
			res = dataProc(word[24:21], modelRegs[word[19:16]], op2, shCarry, modelFlags,
				newFlags);
			if (word[20])
				expFlags = newFlags;
			expWrValid = writesRd(word[24:21]);
			expWrAddr = word[15:12];
			expWrData = res;
		end else if (condHolds(word[31:28], modelFlags) && word[27:25] == 3'b101) begin
			expBranch = 1'b1;
			expPc = branchTarget(modelPc, word[23:0]);
			expWrValid = word[24]; // BL links
			expWrAddr = `CORE_LINK_REG;
			expWrData = modelPc + `CORE_PC_STEP;
		end
		if (expWrValid)
			modelRegs[expWrAddr] = expWrData;
		modelFlags = expFlags;
		modelPc = expPc;
	endtask

	// called 2 ns after an edge; returns 2 ns after the commit checks sampled
	task automatic sendInstr(input logic [31:0] word);
		predictCommit(word);
		instr = word;
		instrValid = 1'b1;
		while (!instrReady) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
		instrValid = 1'b0;
		while (!instrReady) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic loadRegs();
		logic [31:0] rnd;
		for (int r = 0; r < loadCount; r++) begin
			rnd = $random(seed);
			sendInstr(dpWord(4'he, 4'hd, 1'b1, 1'b0, 4'h0, r[3:0], rnd[11:0]));
		end
	endtask

	// arithmetic or compare with S set, for varied flags
	task automatic randomFlags();
		logic [31:0] rnd;
		logic [3:0] op;
		rnd = $random(seed);
		op = {1'b0, rnd[18:16]} + ((rnd[18:16] < 3'd6) ? 4'd2 : 4'd4);
		sendInstr(dpWord(4'he, op, 1'b0, 1'b1, {1'b0, rnd[22:20]}, 4'd13, regField(rnd)));
	endtask

	task automatic dataProcTest();
		logic [31:0] rnd;
		loadRegs();
		for (int op = 0; op < 16; op++) begin
			for (int form = 0; form < 2; form++) begin
				rnd = $random(seed);
				sendInstr(dpWord(4'he, op[3:0], form[0], rnd[20], {1'b0, rnd[18:16]},
					rnd[15:12] % 4'd13, form[0] ? rnd[11:0] : regField(rnd)));
			end
		end
	endtask

	task automatic condTest();
		logic [31:0] rnd;
		loadRegs();
		for (int cond = 0; cond < 15; cond++) begin
			randomFlags();
			rnd = $random(seed);
			sendInstr(dpWord(cond[3:0], rnd[24:21], rnd[25], rnd[20], {1'b0, rnd[18:16]},
				rnd[15:12] % 4'd13, rnd[25] ? rnd[11:0] : regField(rnd)));
		end
	endtask

	task automatic branchTest();
		logic [31:0] rnd;
		loadRegs();
		sendInstr(branchWord(4'he, 1'b0, 5'd3));
		sendInstr(branchWord(4'he, 1'b1, 5'h1c)); // backwards, with link
		for (int i = 0; i < 10; i++) begin
			randomFlags();
			rnd = $random(seed);
			sendInstr(branchWord(rnd[3:0] % 4'd15, rnd[4], rnd[9:5]));
		end
	endtask

	initial begin
		arstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		for (int r = 0; r < 16; r++)
			modelRegs[r] = '0;
		modelFlags = '0;
		modelPc = '0;
		expPcStep = '0;
		expPc = '0;
		expWrValid = 1'b0;
		expWrAddr = '0;
		expWrData = '0;
		expBranch = 1'b0;
		expFlags = '0;
		repeat (resetCycles) @(posedge clk);
		#2;
		arstN = 1'b1;
		dataProcTest();
		condTest();
		branchTest();
		$display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
		if (valueErrors + protocolErrors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// four cycles per instruction plus reset and some slack
	initial begin
		#((instrCount * 4 + resetCycles + 20) * 20);
		$display("timeout: the instruction sequence did not finish in time");
		$display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
		$display("TESTS FAILED");
		$finish;
	end
endmodule
